/* flist.f */
+incdir+include
design/hci_reg_pkg.sv
design/hci_queue_pkg.sv
design/hci_port_if.sv
design/hci_csr.sv
design/hci_write_queue.sv
design/hci_read_queue.sv
design/hci_top.sv
sim/hci_props.sv
sim/hci_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the HCI testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module hci_tb -o hci_tb_sim

# The simulator status is masked by tee, the log decides
./obj_dir/hci_tb_sim | tee sim.log
grep -q "ALL TESTS PASSED" sim.log
echo "Simulation passed"

/* sim/hci_tb.sv */
// HCI queue path testbench

`timescale 1ns/10ps

`include "hci_settings.svh"

module hci_tb;
  import hci_reg_pkg::*;
  import hci_queue_pkg::*;

  localparam int unsigned CLK_PERIOD = 40;
  localparam int unsigned IN_DELAY   = 2;
  localparam int unsigned CMD_DEPTH  = `HCI_CMD_DEPTH;
  localparam int unsigned RESP_DEPTH = `HCI_RESP_DEPTH;
  localparam int unsigned TX_DEPTH   = `HCI_TX_DEPTH;
  localparam int unsigned RX_DEPTH   = `HCI_RX_DEPTH;
  localparam int unsigned N_CMD      = 24;  // Descriptors in the streaming test
  localparam int unsigned N_DATA     = 32;
  localparam int unsigned N_ITER     = 6;
  // About 20 cycles per streamed word and 200 per threshold round
  localparam int unsigned WATCHDOG_CYCLES = 20 * (2 * N_CMD + 3 * N_DATA) + 200 * N_ITER + 500;

  logic      clk_i;
  logic      rst_ni;
  logic      cpu_req_i;
  logic      cpu_req_is_wr_i;
  csr_addr_t cpu_addr_i;
  dword_t    cpu_wr_data_i;
  logic      cpu_rd_ack_o;
  logic      cpu_rd_err_o;
  dword_t    cpu_rd_data_o;
  logic      cpu_wr_ack_o;
  logic      cpu_wr_err_o;
  logic      cmd_rvalid_o;
  logic      cmd_rready_i;
  cmd_desc_t cmd_rdata_o;
  depth_t    cmd_depth_o;
  logic      cmd_ready_thld_trig_o;
  logic      tx_rvalid_o;
  logic      tx_rready_i;
  dword_t    tx_rdata_o;
  depth_t    tx_depth_o;
  logic      tx_ready_thld_trig_o;
  logic      resp_wvalid_i;
  logic      resp_wready_o;
  dword_t    resp_wdata_i;
  depth_t    resp_depth_o;
  logic      resp_ready_thld_trig_o;
  logic      rx_wvalid_i;
  logic      rx_wready_o;
  dword_t    rx_wdata_i;
  depth_t    rx_depth_o;
  logic      rx_ready_thld_trig_o;

  cmd_desc_t   cmd_model[$];
  dword_t      tx_model[$];
  dword_t      resp_model[$];
  dword_t      rx_model[$];
  bit          drain_en = 1'b0;     // Controller drains cmd and TX
  bit          strict_full = 1'b0;  // No software reads in flight
  int unsigned resp_to_push = 0;
  int unsigned rx_to_push = 0;

  hci_top u_dut (.*);

  bind hci_top hci_props u_props (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cpu_rd_ack_i (cpu_rd_ack_o),
    .cpu_rd_err_i (cpu_rd_err_o),
    .cpu_wr_ack_i (cpu_wr_ack_o),
    .cpu_wr_err_i (cpu_wr_err_o),
    .cmd_rvalid_i (cmd_rvalid_o),
    .cmd_depth_i  (cmd_depth_o),
    .tx_rvalid_i  (tx_rvalid_o),
    .tx_depth_i   (tx_depth_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic check_eq(input string name, input logic [63:0] actual,
                          input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic tick();
    @(posedge clk_i);
    #(IN_DELAY);
  endtask

  // One CPU bus access followed by one idle cycle
  task automatic cpu_access(input logic is_wr, input csr_addr_t addr, input dword_t wdata,
                            output dword_t rdata, output logic err);
    int unsigned lat;
    logic        is_port;
    is_port = (addr == ADDR_COMMAND_PORT && is_wr) || (addr == ADDR_RESPONSE_PORT && !is_wr) ||
              (addr == ADDR_XFER_DATA_PORT);
    cpu_req_i       = 1'b1;
    cpu_req_is_wr_i = is_wr;
    cpu_addr_i      = addr;
    cpu_wr_data_i   = wdata;
    lat = 0;
    do begin
      tick();
      lat++;
      cpu_req_i = 1'b0;
    end while (!(cpu_rd_ack_o || cpu_wr_ack_o));
    check_eq("cpu_wr_ack_o", 64'(cpu_wr_ack_o), 64'(is_wr));
    if (is_port) check_eq("port access took two cycles or more", 64'(lat >= 2), 64'd1);
    else check_eq("register access latency", 64'(lat), 64'd1);
    rdata = cpu_rd_data_o;
    err   = is_wr ? cpu_wr_err_o : cpu_rd_err_o;
    tick();
  endtask

  task automatic cpu_write(input csr_addr_t addr, input dword_t wdata);
    dword_t rd;
    logic   err;
    cpu_access(1'b1, addr, wdata, rd, err);
    check_eq("cpu_wr_err_o", 64'(err), 64'd0);
  endtask

  task automatic cpu_read(input csr_addr_t addr, output dword_t rdata);
    logic err;
    cpu_access(1'b0, addr, '0, rdata, err);
    check_eq("cpu_rd_err_o", 64'(err), 64'd0);
  endtask

  task automatic wait_flush_clear();
    dword_t      rd;
    int unsigned tries;
    tries = 0;
    do begin
      cpu_read(ADDR_RESET_CONTROL, rd);
      tries++;
    end while (rd[4:1] != 0 && tries < 3);
    check_eq("RESET_CONTROL after flush", 64'(rd[4:1]), 64'd0);
  endtask

  task automatic check_depths();
    check_eq("cmd_depth_o", 64'(cmd_depth_o), 64'(cmd_model.size()));
    check_eq("tx_depth_o", 64'(tx_depth_o), 64'(tx_model.size()));
    check_eq("resp_depth_o", 64'(resp_depth_o), 64'(resp_model.size()));
    check_eq("rx_depth_o", 64'(rx_depth_o), 64'(rx_model.size()));
  endtask

  // Controller side handshakes land on the coming edge
  initial begin : ctrl_side
    logic take;
    cmd_rready_i  = 1'b0;
    tx_rready_i   = 1'b0;
    resp_wvalid_i = 1'b0;
    resp_wdata_i  = '0;
    rx_wvalid_i   = 1'b0;
    rx_wdata_i    = '0;
    forever begin
      tick();
      if (strict_full) begin
        check_eq("resp_wready_o", 64'(resp_wready_o), 64'(resp_model.size() != RESP_DEPTH));
        check_eq("rx_wready_o", 64'(rx_wready_o), 64'(rx_model.size() != RX_DEPTH));
      end
      take = drain_en && ($urandom_range(0, 3) != 0);
      if (take && cmd_rvalid_o) begin
        if (cmd_model.size() == 0) stop_with_failure("Command descriptor that was never written");
        check_eq("cmd_rdata_o", cmd_rdata_o, cmd_model.pop_front());
      end
      cmd_rready_i = take;
      take = drain_en && ($urandom_range(0, 3) != 0);
      if (take && tx_rvalid_o) begin
        if (tx_model.size() == 0) stop_with_failure("TX word that was never written");
        check_eq("tx_rdata_o", 64'(tx_rdata_o), 64'(tx_model.pop_front()));
      end
      tx_rready_i = take;
      take = (resp_to_push != 0) && ($urandom_range(0, 2) != 0);
      resp_wdata_i = dword_t'($urandom);
      if (take && resp_wready_o) begin
        resp_model.push_back(resp_wdata_i);
        resp_to_push--;
      end
      resp_wvalid_i = take;
      take = (rx_to_push != 0) && ($urandom_range(0, 2) != 0);
      rx_wdata_i = dword_t'($urandom);
      if (take && rx_wready_o) begin
        rx_model.push_back(rx_wdata_i);
        rx_to_push--;
      end
      rx_wvalid_i = take;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    stop_with_failure($sformatf("Timeout, run still busy after %0d cycles", WATCHDOG_CYCLES));
  end

  initial begin : main
    dword_t      w0;
    dword_t      w1;
    dword_t      rd;
    logic        err;
    csr_addr_t   addr;
    int unsigned n_cmd;
    int unsigned n_tx;
    int unsigned q;
    int unsigned cmd_thld;
    int unsigned resp_thld;
    int unsigned tx_code;
    int unsigned rx_code;
    void'($urandom(32'ha5ca_1fe5));
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    cpu_req_i       = 1'b0;
    cpu_req_is_wr_i = 1'b0;
    cpu_addr_i      = '0;
    cpu_wr_data_i   = '0;
    repeat (4) @(posedge clk_i);
    #(IN_DELAY) rst_ni = 1'b1;
    check_eq("cpu_rd_ack_o", 64'(cpu_rd_ack_o), 64'd0);
    check_eq("cpu_wr_ack_o", 64'(cpu_wr_ack_o), 64'd0);
    check_eq("cpu_rd_err_o", 64'(cpu_rd_err_o), 64'd0);
    check_eq("cpu_wr_err_o", 64'(cpu_wr_err_o), 64'd0);
    check_eq("cmd_rvalid_o", 64'(cmd_rvalid_o), 64'd0);
    check_eq("tx_rvalid_o", 64'(tx_rvalid_o), 64'd0);
    check_eq("resp_wready_o", 64'(resp_wready_o), 64'd1);
    check_eq("rx_wready_o", 64'(rx_wready_o), 64'd1);

    // Command and TX streams under random drain
    drain_en = 1'b1;
    n_cmd = 0;
    n_tx = 0;
    while (n_cmd < N_CMD || n_tx < N_DATA) begin
      if (n_tx >= N_DATA || (n_cmd < N_CMD && $urandom_range(0, 1) == 0)) begin
        w0 = dword_t'($urandom);
        w1 = dword_t'($urandom);
        cmd_model.push_back({w1, w0});
        cpu_write(ADDR_COMMAND_PORT, w0);
        cpu_write(ADDR_COMMAND_PORT, w1);
        n_cmd++;
      end else begin
        w0 = dword_t'($urandom);
        tx_model.push_back(w0);
        cpu_write(ADDR_XFER_DATA_PORT, w0);
        n_tx++;
      end
    end
    while (cmd_model.size() != 0 || tx_model.size() != 0) tick();
    drain_en = 1'b0;
    tick();

    // RX and response words read back while the controller pushes
    rx_to_push   = N_DATA;
    resp_to_push = N_DATA / 2;
    for (int i = 0; i < N_DATA; i++) begin
      cpu_read(ADDR_XFER_DATA_PORT, rd);
      if (rx_model.size() == 0) stop_with_failure("RX read returned a word never pushed");
      check_eq("RX word on XFER_DATA_PORT", 64'(rd), 64'(rx_model.pop_front()));
      if (i % 2 == 0) begin
        cpu_read(ADDR_RESPONSE_PORT, rd);
        if (resp_model.size() == 0) stop_with_failure("Response read of a word never pushed");
        check_eq("RESPONSE_PORT word", 64'(rd), 64'(resp_model.pop_front()));
      end
    end

    // wready must drop exactly when the response queue fills
    strict_full  = 1'b1;
    resp_to_push = RESP_DEPTH;
    while (resp_to_push != 0) tick();
    repeat (4) tick();
    strict_full = 1'b0;
    repeat (RESP_DEPTH) begin
      cpu_read(ADDR_RESPONSE_PORT, rd);
      check_eq("RESPONSE_PORT word", 64'(rd), 64'(resp_model.pop_front()));
    end

    // Thresholds and flush on idle queues
    for (int it = 0; it < N_ITER; it++) begin
      n_cmd        = $urandom_range(0, CMD_DEPTH);
      n_tx         = $urandom_range(0, TX_DEPTH);
      resp_to_push = $urandom_range(0, RESP_DEPTH);
      rx_to_push   = $urandom_range(0, RX_DEPTH);
      repeat (n_cmd) begin
        w0 = dword_t'($urandom);
        w1 = dword_t'($urandom);
        cmd_model.push_back({w1, w0});
        cpu_write(ADDR_COMMAND_PORT, w0);
        cpu_write(ADDR_COMMAND_PORT, w1);
      end
      repeat (n_tx) begin
        w0 = dword_t'($urandom);
        tx_model.push_back(w0);
        cpu_write(ADDR_XFER_DATA_PORT, w0);
      end
      while (resp_to_push != 0 || rx_to_push != 0) tick();
      cmd_thld  = $urandom_range(0, 10);
      resp_thld = $urandom_range(0, 10);
      tx_code   = $urandom_range(0, 7);
      rx_code   = $urandom_range(0, 7);
      w0 = {16'h0, 8'(resp_thld), 8'(cmd_thld)};
      w1 = {21'h0, 3'(rx_code), 5'h0, 3'(tx_code)};
      cpu_write(ADDR_QUEUE_THLD_CTRL, w0);
      cpu_write(ADDR_DATA_BUFFER_THLD_CTRL, w1);
      cpu_read(ADDR_QUEUE_THLD_CTRL, rd);
      check_eq("QUEUE_THLD_CTRL", 64'(rd), 64'(w0));
      cpu_read(ADDR_DATA_BUFFER_THLD_CTRL, rd);
      check_eq("DATA_BUFFER_THLD_CTRL", 64'(rd), 64'(w1));
      check_depths();
      if (cmd_thld == 0) cmd_thld = 1;  // Zero counts as one
      if (resp_thld == 0) resp_thld = 1;
      check_eq("cmd_ready_thld_trig_o", 64'(cmd_ready_thld_trig_o),
               64'((CMD_DEPTH - cmd_model.size()) >= cmd_thld));
      check_eq("tx_ready_thld_trig_o", 64'(tx_ready_thld_trig_o),
               64'((TX_DEPTH - tx_model.size()) >= (1 << (tx_code + 1))));
      check_eq("resp_ready_thld_trig_o", 64'(resp_ready_thld_trig_o),
               64'(resp_model.size() >= resp_thld));
      check_eq("rx_ready_thld_trig_o", 64'(rx_ready_thld_trig_o),
               64'(rx_model.size() >= (1 << (rx_code + 1))));

      // Bit 1 cmd, 2 resp, 3 TX, 4 RX
      q = (it % 4) + 1;  // Each flush bit in turn
      cpu_write(ADDR_RESET_CONTROL, dword_t'(1) << q);
      wait_flush_clear();
      case (q)
        1: cmd_model.delete();
        2: resp_model.delete();
        3: tx_model.delete();
        default: rx_model.delete();
      endcase
      check_depths();

      // The other queues still give back their words in order
      drain_en = 1'b1;
      while (cmd_model.size() != 0 || tx_model.size() != 0) tick();
      drain_en = 1'b0;
      tick();
      while (resp_model.size() != 0) begin
        cpu_read(ADDR_RESPONSE_PORT, rd);
        check_eq("RESPONSE_PORT word", 64'(rd), 64'(resp_model.pop_front()));
      end
      while (rx_model.size() != 0) begin
        cpu_read(ADDR_XFER_DATA_PORT, rd);
        check_eq("RX word on XFER_DATA_PORT", 64'(rd), 64'(rx_model.pop_front()));
      end
      check_depths();
    end

    // Bad accesses answer with err after one cycle
    cpu_access(1'b1, ADDR_RESPONSE_PORT, dword_t'($urandom), rd, err);
    check_eq("cpu_wr_err_o on RESPONSE_PORT write", 64'(err), 64'd1);
    cpu_access(1'b0, ADDR_COMMAND_PORT, '0, rd, err);
    check_eq("cpu_rd_err_o on COMMAND_PORT read", 64'(err), 64'd1);
    repeat (8) begin
      addr = csr_addr_t'($urandom_range(32'h18, 32'hFFF));
      cpu_access($urandom_range(0, 1) == 1, addr, dword_t'($urandom), rd, err);
      check_eq("err on unmapped address", 64'(err), 64'd1);
    end
    check_depths();

    if (u_dut.u_props.fail_cnt != 0) begin
      $display("Protocol assertions failed %0d times", u_dut.u_props.fail_cnt);
      $display("SOME TESTS FAILED");
      $fatal(1, "assertion failures");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

/* sim/hci_props.sv */
// HCI top level protocol assertions

`timescale 1ns/10ps

module hci_props (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  cpu_rd_ack_i,
  input logic                  cpu_rd_err_i,
  input logic                  cpu_wr_ack_i,
  input logic                  cpu_wr_err_i,
  input logic                  cmd_rvalid_i,
  input hci_queue_pkg::depth_t cmd_depth_i,
  input logic                  tx_rvalid_i,
  input hci_queue_pkg::depth_t tx_depth_i
);

  int unsigned fail_cnt = 0;  // Assertion failures so far

  a_no_ack_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !(cpu_rd_ack_i || cpu_wr_ack_i))
    else begin
      fail_cnt++;
      $error("CPU ack while reset is asserted");
    end

  a_rd_err_with_ack: assert property (@(posedge clk_i) cpu_rd_err_i |-> cpu_rd_ack_i)
    else begin
      fail_cnt++;
      $error("Read error without read ack");
    end

  a_wr_err_with_ack: assert property (@(posedge clk_i) cpu_wr_err_i |-> cpu_wr_ack_i)
    else begin
      fail_cnt++;
      $error("Write error without write ack");
    end

  a_single_ack: assert property (@(posedge clk_i) !(cpu_rd_ack_i && cpu_wr_ack_i))
    else begin
      fail_cnt++;
      $error("Read and write ack in the same cycle");
    end

  // Nothing to offer from an empty queue
  a_cmd_empty: assert property (@(posedge clk_i) (cmd_depth_i == '0) |-> !cmd_rvalid_i)
    else begin
      fail_cnt++;
      $error("Command rvalid with zero depth");
    end

  a_tx_empty: assert property (@(posedge clk_i) (tx_depth_i == '0) |-> !tx_rvalid_i)
    else begin
      fail_cnt++;
      $error("TX rvalid with zero depth");
    end

endmodule

/* design/hci_top.sv */
// I3C HCI PIO queue path

`timescale 1ns/10ps

`include "hci_settings.svh"

module hci_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      cpu_req_i,
  input  logic                      cpu_req_is_wr_i,
  input  hci_reg_pkg::csr_addr_t    cpu_addr_i,
  input  hci_queue_pkg::dword_t     cpu_wr_data_i,
  output logic                      cpu_rd_ack_o,
  output logic                      cpu_rd_err_o,
  output hci_queue_pkg::dword_t     cpu_rd_data_o,
  output logic                      cpu_wr_ack_o,
  output logic                      cpu_wr_err_o,
  // Command queue
  output logic                      cmd_rvalid_o,
  input  logic                      cmd_rready_i,
  output hci_queue_pkg::cmd_desc_t  cmd_rdata_o,
  output hci_queue_pkg::depth_t     cmd_depth_o,
  output logic                      cmd_ready_thld_trig_o,
  // TX data
  output logic                      tx_rvalid_o,
  input  logic                      tx_rready_i,
  output hci_queue_pkg::dword_t     tx_rdata_o,
  output hci_queue_pkg::depth_t     tx_depth_o,
  output logic                      tx_ready_thld_trig_o,
  // Response queue
  input  logic                      resp_wvalid_i,
  output logic                      resp_wready_o,
  input  hci_queue_pkg::dword_t     resp_wdata_i,
  output hci_queue_pkg::depth_t     resp_depth_o,
  output logic                      resp_ready_thld_trig_o,
  // RX data
  input  logic                      rx_wvalid_i,
  output logic                      rx_wready_o,
  input  hci_queue_pkg::dword_t     rx_wdata_i,
  output hci_queue_pkg::depth_t     rx_depth_o,
  output logic                      rx_ready_thld_trig_o
);

  hci_port_if cmd_if ();
  hci_port_if tx_if ();
  hci_port_if resp_if ();
  hci_port_if rx_if ();

  hci_csr u_csr (
    .clk_i,
    .rst_ni,
    .cpu_req_i,
    .cpu_req_is_wr_i,
    .cpu_addr_i,
    .cpu_wr_data_i,
    .cpu_rd_ack_o,
    .cpu_rd_err_o,
    .cpu_rd_data_o,
    .cpu_wr_ack_o,
    .cpu_wr_err_o,
    .cmd_port  (cmd_if),
    .tx_port   (tx_if),
    .resp_port (resp_if),
    .rx_port   (rx_if)
  );

  // Two CSR words per command descriptor
  hci_write_queue #(
    .Depth     (`HCI_CMD_DEPTH),
    .DataWidth (2 * `HCI_DWORD_W)
  ) u_cmd_queue (
    .clk_i,
    .rst_ni,
    .port              (cmd_if),
    .rvalid_o          (cmd_rvalid_o),
    .rready_i          (cmd_rready_i),
    .rdata_o           (cmd_rdata_o),
    .depth_o           (cmd_depth_o),
    .ready_thld_trig_o (cmd_ready_thld_trig_o)
  );

  hci_write_queue #(
    .Depth     (`HCI_TX_DEPTH),
    .DataWidth (`HCI_DWORD_W)
  ) u_tx_queue (
    .clk_i,
    .rst_ni,
    .port              (tx_if),
    .rvalid_o          (tx_rvalid_o),
    .rready_i          (tx_rready_i),
    .rdata_o           (tx_rdata_o),
    .depth_o           (tx_depth_o),
    .ready_thld_trig_o (tx_ready_thld_trig_o)
  );

  hci_read_queue #(
    .Depth (`HCI_RESP_DEPTH)
  ) u_resp_queue (
    .clk_i,
    .rst_ni,
    .port              (resp_if),
    .wvalid_i          (resp_wvalid_i),
    .wready_o          (resp_wready_o),
    .wdata_i           (resp_wdata_i),
    .depth_o           (resp_depth_o),
    .ready_thld_trig_o (resp_ready_thld_trig_o)
  );

  hci_read_queue #(
    .Depth (`HCI_RX_DEPTH)
  ) u_rx_queue (
    .clk_i,
    .rst_ni,
    .port              (rx_if),
    .wvalid_i          (rx_wvalid_i),
    .wready_o          (rx_wready_o),
    .wdata_i           (rx_wdata_i),
    .depth_o           (rx_depth_o),
    .ready_thld_trig_o (rx_ready_thld_trig_o)
  );

endmodule

/* design/hci_read_queue.sv */
// Controller to software queue

`timescale 1ns/10ps

module hci_read_queue #(
  parameter int unsigned Depth = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  hci_port_if.queue_mp          port,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  input  hci_queue_pkg::dword_t wdata_i,
  output hci_queue_pkg::depth_t depth_o,
  output logic                  ready_thld_trig_o
);
  import hci_queue_pkg::*;

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  dword_t          mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  depth_t          depth_q;
  logic            push;
  logic            pop;
  logic            flush_done_q;

  function automatic logic [PtrW-1:0] ptr_inc(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wready_o = (depth_q != depth_t'(Depth)) && !port.flush;
  assign push     = wvalid_i && wready_o;

  // Software pop, data valid with ack
  assign port.ack        = port.req && (depth_q != '0) && !port.flush;
  assign port.rdata      = mem_q[rd_ptr_q];
  assign port.flush_done = flush_done_q;
  assign pop             = port.ack;

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= wdata_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      depth_q      <= '0;
      flush_done_q <= 1'b0;
    end else begin
      flush_done_q <= port.flush && !flush_done_q;
      if (port.flush) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        depth_q  <= '0;
      end else begin
        if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
        if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
        depth_q <= depth_q + depth_t'(push) - depth_t'(pop);
      end
    end
  end

  assign ready_thld_trig_o = 32'(depth_q) >= 32'(port.ready_thld);  // Enough to read
  assign depth_o           = depth_q;

endmodule

/* design/hci_write_queue.sv */
// Software to controller queue

`timescale 1ns/10ps

module hci_write_queue #(
  parameter int unsigned Depth     = 8,
  parameter int unsigned DataWidth = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  hci_port_if.queue_mp          port,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  output logic [DataWidth-1:0]  rdata_o,
  output hci_queue_pkg::depth_t depth_o,
  output logic                  ready_thld_trig_o
);
  import hci_queue_pkg::*;

  localparam int unsigned Words = DataWidth / $bits(dword_t);  // Words per entry
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned WcntW = (Words > 1) ? $clog2(Words) : 1;

  logic [DataWidth-1:0] mem_q [Depth];
  logic [DataWidth-1:0] pack_q;
  logic [DataWidth-1:0] pack_d;
  logic [PtrW-1:0]      wr_ptr_q;
  logic [PtrW-1:0]      rd_ptr_q;
  logic [WcntW-1:0]     wcnt_q;
  depth_t               depth_q;
  depth_t               free_cnt;
  logic                 full;
  logic                 last_word;
  logic                 push;
  logic                 pop;
  logic                 flush_done_q;

  function automatic logic [PtrW-1:0] ptr_inc(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full      = depth_q == depth_t'(Depth);
  assign last_word = wcnt_q == WcntW'(Words - 1);

  // Every word is acked, the entry is pushed with its last word
  assign port.ack        = port.req && !port.flush && !full;
  assign port.rdata      = '0;
  assign port.flush_done = flush_done_q;
  assign push            = port.ack && last_word;

  assign rvalid_o = (depth_q != '0) && !port.flush;
  assign pop      = rvalid_o && rready_i;
  assign rdata_o  = mem_q[rd_ptr_q];

  always_comb begin
    pack_d = pack_q;
    pack_d[wcnt_q * $bits(dword_t) +: $bits(dword_t)] = port.wdata;  // Low word first
  end

  always_ff @(posedge clk_i) begin
    if (port.ack) pack_q <= pack_d;
    if (push) mem_q[wr_ptr_q] <= pack_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      wcnt_q       <= '0;
      depth_q      <= '0;
      flush_done_q <= 1'b0;
    end else begin
      flush_done_q <= port.flush && !flush_done_q;
      if (port.flush) begin  // Drops a half-packed entry too
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        wcnt_q   <= '0;
        depth_q  <= '0;
      end else begin
        if (port.ack) wcnt_q <= last_word ? '0 : wcnt_q + 1'b1;
        if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
        if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
        depth_q <= depth_q + depth_t'(push) - depth_t'(pop);
      end
    end
  end

  assign free_cnt          = depth_t'(Depth) - depth_q;
  assign ready_thld_trig_o = 32'(free_cnt) >= 32'(port.ready_thld);  // Enough room
  assign depth_o           = depth_q;

endmodule

/* design/hci_csr.sv */
// HCI CSR decode and port sequencing

`timescale 1ns/10ps

module hci_csr (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   cpu_req_i,
  input  logic                   cpu_req_is_wr_i,
  input  hci_reg_pkg::csr_addr_t cpu_addr_i,
  input  hci_queue_pkg::dword_t  cpu_wr_data_i,
  output logic                   cpu_rd_ack_o,
  output logic                   cpu_rd_err_o,
  output hci_queue_pkg::dword_t  cpu_rd_data_o,
  output logic                   cpu_wr_ack_o,
  output logic                   cpu_wr_err_o,
  hci_port_if.csr_mp             cmd_port,
  hci_port_if.csr_mp             tx_port,
  hci_port_if.csr_mp             resp_port,
  hci_port_if.csr_mp             rx_port
);
  import hci_reg_pkg::*;
  import hci_queue_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    PORT_WAIT,
    RESP
  } state_e;

  state_e      state_q;
  queue_sel_e  sel_q;
  queue_sel_e  acc_sel;
  logic        is_wr_q;
  logic        err_q;
  logic        acc_port;
  logic        acc_err;
  logic        reg_wr;
  logic        port_ack;
  dword_t      acc_rdata;
  dword_t      port_rdata;
  dword_t      wdata_q;
  dword_t      rdata_q;
  thld_t       cmd_thld_q;
  thld_t       resp_thld_q;
  buf_thld_t   tx_code_q;
  buf_thld_t   rx_code_q;
  reset_ctrl_t rst_q;
  reset_ctrl_t flush_done;

  function automatic thld_t queue_thld(thld_t val);
    return (val == '0) ? thld_t'(1) : val;  // Zero acts as one
  endfunction

  // Code N means 2^(N+1) entries, top code saturates
  function automatic thld_t buf_thld(buf_thld_t code);
    return (code == '1) ? '1 : thld_t'(2) << code;
  endfunction

  always_comb begin
    acc_port  = 1'b0;
    acc_err   = 1'b0;
    acc_sel   = QUEUE_CMD;
    acc_rdata = '0;
    case (cpu_addr_i)
      ADDR_COMMAND_PORT: begin
        acc_port = cpu_req_is_wr_i;
        acc_err  = !cpu_req_is_wr_i;
      end
      ADDR_RESPONSE_PORT: begin
        acc_port = !cpu_req_is_wr_i;
        acc_err  = cpu_req_is_wr_i;
        acc_sel  = QUEUE_RESP;
      end
      ADDR_XFER_DATA_PORT: begin
        acc_port = 1'b1;
        acc_sel  = cpu_req_is_wr_i ? QUEUE_TX : QUEUE_RX;
      end
      ADDR_QUEUE_THLD_CTRL: begin
        acc_rdata[CMD_THLD_LSB +: $bits(thld_t)]  = cmd_thld_q;
        acc_rdata[RESP_THLD_LSB +: $bits(thld_t)] = resp_thld_q;
      end
      ADDR_DATA_BUFFER_THLD_CTRL: begin
        acc_rdata[TX_BUF_THLD_LSB +: $bits(buf_thld_t)] = tx_code_q;
        acc_rdata[RX_BUF_THLD_LSB +: $bits(buf_thld_t)] = rx_code_q;
      end
      ADDR_RESET_CONTROL: acc_rdata[RST_MSB:RST_LSB] = rst_q;  // Live flush state
      default: acc_err = 1'b1;
    endcase
  end

  assign reg_wr = (state_q == IDLE) && cpu_req_i && cpu_req_is_wr_i;

  always_comb begin
    flush_done = '0;
    flush_done[QUEUE_CMD]  = cmd_port.flush_done;
    flush_done[QUEUE_RESP] = resp_port.flush_done;
    flush_done[QUEUE_TX]   = tx_port.flush_done;
    flush_done[QUEUE_RX]   = rx_port.flush_done;
    case (sel_q)
      QUEUE_CMD:  {port_ack, port_rdata} = {cmd_port.ack, cmd_port.rdata};
      QUEUE_RESP: {port_ack, port_rdata} = {resp_port.ack, resp_port.rdata};
      QUEUE_TX:   {port_ack, port_rdata} = {tx_port.ack, tx_port.rdata};
      QUEUE_RX:   {port_ack, port_rdata} = {rx_port.ack, rx_port.rdata};
      default:    {port_ack, port_rdata} = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      sel_q   <= QUEUE_CMD;
      is_wr_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (cpu_req_i) begin
            sel_q   <= acc_sel;
            is_wr_q <= cpu_req_is_wr_i;
            err_q   <= acc_err;
            state_q <= acc_port ? PORT_WAIT : RESP;
          end
        end
        PORT_WAIT: if (port_ack) state_q <= RESP;
        default: state_q <= IDLE;  // RESP lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_thld_q  <= '0;
      resp_thld_q <= '0;
      tx_code_q   <= '0;
      rx_code_q   <= '0;
      rst_q       <= '0;
    end else begin
      if (reg_wr && cpu_addr_i == ADDR_QUEUE_THLD_CTRL) begin
        cmd_thld_q  <= cpu_wr_data_i[CMD_THLD_LSB +: $bits(thld_t)];
        resp_thld_q <= cpu_wr_data_i[RESP_THLD_LSB +: $bits(thld_t)];
      end
      if (reg_wr && cpu_addr_i == ADDR_DATA_BUFFER_THLD_CTRL) begin
        tx_code_q <= cpu_wr_data_i[TX_BUF_THLD_LSB +: $bits(buf_thld_t)];
        rx_code_q <= cpu_wr_data_i[RX_BUF_THLD_LSB +: $bits(buf_thld_t)];
      end
      // Hardware clears on done, software sets
      rst_q <= (rst_q & ~flush_done) |
               ((reg_wr && cpu_addr_i == ADDR_RESET_CONTROL) ?
                cpu_wr_data_i[RST_MSB:RST_LSB] : '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && cpu_req_i) begin
      wdata_q <= cpu_wr_data_i;
      rdata_q <= acc_rdata;
    end else if (state_q == PORT_WAIT && port_ack) begin
      rdata_q <= port_rdata;
    end
  end

  assign cmd_port.req         = (state_q == PORT_WAIT) && (sel_q == QUEUE_CMD);
  assign cmd_port.wdata       = wdata_q;
  assign cmd_port.ready_thld  = queue_thld(cmd_thld_q);
  assign cmd_port.flush       = rst_q[QUEUE_CMD];
  assign resp_port.req        = (state_q == PORT_WAIT) && (sel_q == QUEUE_RESP);
  assign resp_port.wdata      = wdata_q;
  assign resp_port.ready_thld = queue_thld(resp_thld_q);
  assign resp_port.flush      = rst_q[QUEUE_RESP];
  assign tx_port.req          = (state_q == PORT_WAIT) && (sel_q == QUEUE_TX);
  assign tx_port.wdata        = wdata_q;
  assign tx_port.ready_thld   = buf_thld(tx_code_q);
  assign tx_port.flush        = rst_q[QUEUE_TX];
  assign rx_port.req          = (state_q == PORT_WAIT) && (sel_q == QUEUE_RX);
  assign rx_port.wdata        = wdata_q;
  assign rx_port.ready_thld   = buf_thld(rx_code_q);
  assign rx_port.flush        = rst_q[QUEUE_RX];

  assign cpu_rd_ack_o  = (state_q == RESP) && !is_wr_q;
  assign cpu_wr_ack_o  = (state_q == RESP) && is_wr_q;
  assign cpu_rd_err_o  = cpu_rd_ack_o && err_q;
  assign cpu_wr_err_o  = cpu_wr_ack_o && err_q;
  assign cpu_rd_data_o = rdata_q;

endmodule

/* design/hci_port_if.sv */
// CSR to queue port

`timescale 1ns/10ps

interface hci_port_if;
  import hci_queue_pkg::*;

  logic   req;         // Access pending until ack
  logic   ack;
  dword_t wdata;
  dword_t rdata;       // Valid with ack
  thld_t  ready_thld;
  logic   flush;       // Level, held until flush_done
  logic   flush_done;

  modport csr_mp (
    output req, wdata, ready_thld, flush,
    input  ack, rdata, flush_done
  );

  modport queue_mp (
    input  req, wdata, ready_thld, flush,
    output ack, rdata, flush_done
  );

endinterface

/* design/hci_queue_pkg.sv */
// HCI queue data types

`include "hci_settings.svh"

package hci_queue_pkg;

  typedef logic [`HCI_DWORD_W-1:0] dword_t;
  typedef logic [2*`HCI_DWORD_W-1:0] cmd_desc_t;  // Two words, low first
  typedef logic [7:0] thld_t;

  localparam int unsigned CTRL_DEPTH_MAX =
      (`HCI_CMD_DEPTH > `HCI_RESP_DEPTH) ? `HCI_CMD_DEPTH : `HCI_RESP_DEPTH;
  localparam int unsigned DATA_DEPTH_MAX =
      (`HCI_TX_DEPTH > `HCI_RX_DEPTH) ? `HCI_TX_DEPTH : `HCI_RX_DEPTH;
  localparam int unsigned DEPTH_MAX =
      (CTRL_DEPTH_MAX > DATA_DEPTH_MAX) ? CTRL_DEPTH_MAX : DATA_DEPTH_MAX;

  // Occupancy counts up to and including the full depth
  localparam int unsigned DEPTH_W = $clog2(DEPTH_MAX + 1);

  typedef logic [DEPTH_W-1:0] depth_t;

endpackage

/* design/hci_reg_pkg.sv */
// HCI PIO register map

`include "hci_settings.svh"

package hci_reg_pkg;

  typedef logic [`HCI_CSR_AW-1:0] csr_addr_t;

  localparam csr_addr_t ADDR_COMMAND_PORT          = 'h00;  // Write only
  localparam csr_addr_t ADDR_RESPONSE_PORT         = 'h04;  // Read only
  localparam csr_addr_t ADDR_XFER_DATA_PORT        = 'h08;  // Write TX, read RX
  localparam csr_addr_t ADDR_QUEUE_THLD_CTRL       = 'h0C;
  localparam csr_addr_t ADDR_DATA_BUFFER_THLD_CTRL = 'h10;
  localparam csr_addr_t ADDR_RESET_CONTROL         = 'h14;

  localparam int unsigned CMD_THLD_LSB    = 0;
  localparam int unsigned RESP_THLD_LSB   = 8;
  localparam int unsigned TX_BUF_THLD_LSB = 0;
  localparam int unsigned RX_BUF_THLD_LSB = 8;
  localparam int unsigned RST_LSB         = 1;  // Queue reset bits
  localparam int unsigned RST_MSB         = 4;

  typedef logic [2:0] buf_thld_t;
  typedef logic [RST_MSB:RST_LSB] reset_ctrl_t;

  // Values are the RESET_CONTROL bit positions
  typedef enum logic [2:0] {
    QUEUE_CMD  = 3'd1,
    QUEUE_RESP = 3'd2,
    QUEUE_TX   = 3'd3,
    QUEUE_RX   = 3'd4
  } queue_sel_e;

endpackage

/* include/hci_settings.svh */
// HCI queue path settings

`ifndef HCI_SETTINGS_SVH
`define HCI_SETTINGS_SVH

// Entries per queue
`define HCI_CMD_DEPTH 8
`define HCI_RESP_DEPTH 8
`define HCI_TX_DEPTH 8
`define HCI_RX_DEPTH 8

// CPU bus address width
`define HCI_CSR_AW 12

// CSR and data word width
`define HCI_DWORD_W 32

`endif
